/* design/irq_pkg.sv */
// Shared types, register addresses and vector constants for the interrupt controller
`default_nettype none

package irq_pkg;

	// CPU bus widths
	typedef logic [15:0] addr_t;          // Bus address
	typedef logic [7:0]  data_t;          // Bus data byte

	// One bit per interrupt source, bit 0 has highest priority
	typedef logic [7:0]  irq_mask_t;

	// Source number, 0 to 7
	typedef logic [2:0]  irq_idx_t;

	// Memory bus request from the CPU
	typedef struct packed {
		addr_t addr;                      // Target address
		data_t wdata;                     // Write data
		logic  wr;                        // One-cycle write strobe
		logic  rd;                        // One-cycle read strobe
	} bus_req_t;

	// IME commands decoded by the CPU
	typedef enum logic [1:0] {
		cmd_none = 2'd0,
		cmd_ei   = 2'd1,                  // Enable IME
		cmd_di   = 2'd2,                  // Disable IME
		cmd_reti = 2'd3                   // Return from handler, enables IME
	} irq_cmd_t;

	// Dispatcher state
	typedef enum logic [0:0] {
		st_idle = 1'b0,
		st_take = 1'b1                    // Take cycle, strobe and clear
	} disp_state_t;

	// Register map
	localparam addr_t ADDR_IE = 16'hFFFF;
	localparam addr_t ADDR_IF = 16'hFF0F;

	// Vector n lives at VEC_BASE + n * VEC_STRIDE
	localparam addr_t VEC_BASE   = 16'h0040;
	localparam addr_t VEC_STRIDE = 16'd8;

endpackage

`default_nettype wire

/* design/irq_sync.sv */
// Samples peripheral request levels and emits a one-cycle set strobe per rising edge
`timescale 1ns/10ps
`default_nettype none

module irq_sync #(
	parameter int unsigned N_SRC = 5
) (
	input  wire                 clk,
	input  wire                 reset,
	input  irq_pkg::irq_mask_t  req,
	output irq_pkg::irq_mask_t  set_strb
);

	import irq_pkg::*;

	// Only implemented sources pass
	localparam irq_mask_t SRC_MASK = irq_mask_t'((1 << N_SRC) - 1);

	irq_mask_t req_q;                     // Sample taken on the last edge
	irq_mask_t req_qq;                    // Sample before that

	// Two-deep request history
	always_ff @(posedge clk) begin
		if (reset) begin
			req_q  <= '0;
			req_qq <= '0;
		end else begin
			req_q  <= req & SRC_MASK;
			req_qq <= req_q;
		end
	end

	// A bit that is high now but was low one sample earlier has just risen.
	// The strobe is high for the one cycle after the first high sample,
	// so the flag register picks it up on the following edge.
	assign set_strb = req_q & ~req_qq & SRC_MASK;

endmodule

`default_nettype wire

/* design/irq_regs.sv */
// IE and IF register file, decoded on the CPU bus, feeding the dispatcher with active requests
`timescale 1ns/10ps
`default_nettype none

module irq_regs #(
	parameter int unsigned N_SRC = 5
) (
	input  wire                 clk,
	input  wire                 reset,
	input  irq_pkg::bus_req_t   bus,
	input  irq_pkg::irq_mask_t  set_strb,
	input  irq_pkg::irq_mask_t  clr_strb,
	output irq_pkg::data_t      rdata,
	output logic                rdata_valid,
	output irq_pkg::irq_mask_t  active
);

	import irq_pkg::*;

	// Implemented source bits
	localparam irq_mask_t SRC_MASK = irq_mask_t'((1 << N_SRC) - 1);

	irq_mask_t        ie_q;               // Interrupt enable, all 8 bits
	logic [N_SRC-1:0] if_q;               // Interrupt flags
	logic [N_SRC-1:0] if_next;
	irq_mask_t        if_full;            // Flags widened to 8 bits

	logic  sel_ie;
	logic  sel_if;
	logic  wr_ie;
	logic  wr_if;
	logic  rd_hit;
	data_t rdata_next;

	// Address decode
	assign sel_ie = (bus.addr == ADDR_IE);
	assign sel_if = (bus.addr == ADDR_IF);

	assign wr_ie  = bus.wr & sel_ie;
	assign wr_if  = bus.wr & sel_if;
	assign rd_hit = bus.rd & (sel_ie | sel_if);

	assign if_full = irq_mask_t'(if_q);

	// Flag update order: bus write, then dispatcher clear, then edge set.
	// Applying the set last lets a new request win over both.
	always_comb begin
		if_next = if_q;
		if (wr_if) begin
			if_next = bus.wdata[N_SRC-1:0];
		end
		if_next = if_next & ~clr_strb[N_SRC-1:0];   // Taken interrupt
		if_next = if_next | set_strb[N_SRC-1:0];    // New edges
	end

	// Register state
	always_ff @(posedge clk) begin
		if (reset) begin
			ie_q        <= '0;
			if_q        <= '0;
			rdata_valid <= 1'b0;
		end else begin
			if (wr_ie) begin
				ie_q <= bus.wdata;
			end
			if_q        <= if_next;
			rdata_valid <= rd_hit;
		end
	end

	// Read mux, unimplemented IF bits read as 1
	always_comb begin
		if (sel_ie) begin
			rdata_next = data_t'(ie_q);
		end else begin
			rdata_next = data_t'(if_full | ~SRC_MASK);
		end
	end

	// Read data lands one cycle after the strobe
	always_ff @(posedge clk) begin
		if (rd_hit) begin
			rdata <= rdata_next;
		end
	end

	// Requests both flagged and enabled
	assign active = ie_q & if_full;

endmodule

`default_nettype wire

/* design/irq_dispatch.sv */
// Interrupt dispatcher: holds IME, picks the highest priority request and issues the take strobe
`timescale 1ns/10ps
`default_nettype none

module irq_dispatch #(
	parameter int unsigned N_SRC = 5
) (
	input  wire                 clk,
	input  wire                 reset,
	input  irq_pkg::irq_mask_t  active,
	input  irq_pkg::irq_cmd_t   cmd,
	input  wire                 boundary,
	output logic                take,
	output irq_pkg::addr_t      vector,
	output irq_pkg::irq_mask_t  clr_strb,
	output logic                pending
);

	import irq_pkg::*;

	disp_state_t state;
	disp_state_t state_next;

	logic ime;                            // Master interrupt enable
	logic ime_next;

	irq_idx_t sel_idx;                    // Lowest pending source
	logic     sel_valid;
	irq_idx_t take_idx;                   // Source being taken
	logic     start;

	// Priority encoder over implemented sources.
	// Scanning downward leaves the lowest set bit in sel_idx.
	always_comb begin
		sel_valid = 1'b0;
		sel_idx   = '0;
		for (int i = N_SRC - 1; i >= 0; i--) begin
			if (active[i]) begin
				sel_valid = 1'b1;
				sel_idx   = irq_idx_t'(i);
			end
		end
	end

	// Boundary uses the IME value from before this cycle's command
	assign start = (state == st_idle) & boundary & ime & sel_valid;

	// Take FSM
	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (start) begin
					state_next = st_take;
				end
			end
			st_take: state_next = st_idle;    // Single take cycle
			default: state_next = st_idle;
		endcase
	end

	// IME update
	always_comb begin
		ime_next = ime;
		case (cmd)
			cmd_ei,
			cmd_reti: ime_next = 1'b1;
			cmd_di:   ime_next = 1'b0;
			default:  ime_next = ime;
		endcase
		// Entering a handler always disables further interrupts
		if (take) begin
			ime_next = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			ime   <= 1'b0;
		end else begin
			state <= state_next;
			ime   <= ime_next;
		end
	end

	// Winner captured at the boundary
	always_ff @(posedge clk) begin
		if (start) begin
			take_idx <= sel_idx;
		end
	end

	// Take outputs
	assign take     = (state == st_take);
	assign clr_strb = take ? (irq_mask_t'(1) << take_idx) : '0;
	assign vector   = VEC_BASE + addr_t'(take_idx) * VEC_STRIDE;

	// Wake-up level, independent of IME
	assign pending  = |active;

endmodule

`default_nettype wire

/* design/irq_top.sv */
// Interrupt controller top level, wiring edge sampler, IE/IF registers and dispatcher
`timescale 1ns/10ps
`default_nettype none

module irq_top #(
	parameter int unsigned N_SRC = 5
) (
	input  wire                 clk,
	input  wire                 reset,
	// CPU bus
	input  irq_pkg::bus_req_t   bus,
	output irq_pkg::data_t      rdata,
	output logic                rdata_valid,
	// Peripheral request levels
	input  irq_pkg::irq_mask_t  req,
	// CPU control
	input  irq_pkg::irq_cmd_t   cmd,
	input  wire                 boundary,
	output logic                take,
	output irq_pkg::addr_t      vector,
	output logic                pending
);

	import irq_pkg::*;

	irq_mask_t set_strb;                  // Rising edges to IF
	irq_mask_t clr_strb;                  // Taken flag to IF
	irq_mask_t active;                    // IE & IF

	irq_sync #(
		.N_SRC (N_SRC)
	) u_irq_sync (
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.set_strb (set_strb)
	);

	irq_regs #(
		.N_SRC (N_SRC)
	) u_irq_regs (
		.clk         (clk),
		.reset       (reset),
		.bus         (bus),
		.set_strb    (set_strb),
		.clr_strb    (clr_strb),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.active      (active)
	);

	irq_dispatch #(
		.N_SRC (N_SRC)
	) u_irq_dispatch (
		.clk      (clk),
		.reset    (reset),
		.active   (active),
		.cmd      (cmd),
		.boundary (boundary),
		.take     (take),
		.vector   (vector),
		.clr_strb (clr_strb),
		.pending  (pending)
	);

endmodule

`default_nettype wire

/* test/irq_top_assert.sv */
// Concurrent checks on the take and clear strobes that bind attaches to irq_top
`timescale 1ns/10ps
`default_nettype none

module irq_top_assert (
	input wire                 clk,
	input wire                 reset,
	input wire                 take,
	input irq_pkg::irq_mask_t  clr_strb,
	input irq_pkg::irq_mask_t  active,
	input wire                 boundary,
	input wire                 ime
);

	// Take lasts one cycle
	take_single: assert property (@(posedge clk) disable iff (reset)
		take |=> !take)
		else $error("take held high for two cycles");

	clr_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(clr_strb))
		else $error("clr_strb has more than one bit set");

	// Clear travels with take and never without it
	clr_with_take: assert property (@(posedge clk) disable iff (reset)
		((clr_strb != '0) == take))
		else $error("clr_strb and take disagree");

	// Cleared flag is the lowest active one seen at the boundary
	clr_lowest: assert property (@(posedge clk) disable iff (reset)
		take |-> (clr_strb == ($past(active) & (~$past(active) + 8'd1))))
		else $error("clr_strb is not the lowest active flag");

	take_after_boundary: assert property (@(posedge clk) disable iff (reset)
		take |-> $past(boundary && ime))
		else $error("take without a boundary under IME");

endmodule

bind irq_top irq_top_assert u_irq_top_assert (
	.clk      (clk),
	.reset    (reset),
	.take     (take),
	.clr_strb (clr_strb),
	.active   (active),
	.boundary (boundary),
	.ime      (u_irq_dispatch.ime)
);

`default_nettype wire

/* test/tb_irq_top.sv */
// Directed testbench that drives irq_top through register, edge, priority, IME and IE tests
`timescale 1ns/10ps
`default_nettype none

module tb_irq_top;

	import irq_pkg::*;

	localparam int unsigned N_SRC = 5;
	localparam int READ_TIMEOUT = 8;      // Cycles to wait for rdata_valid
	localparam int TAKE_TIMEOUT = 6;      // Cycles to wait for take

	logic       clk;
	logic       reset;
	bus_req_t   bus;
	data_t      rdata;
	logic       rdata_valid;
	irq_mask_t  req;
	irq_cmd_t   cmd;
	logic       boundary;
	logic       take;
	addr_t      vector;
	logic       pending;
	logic [31:0] lfsr;

	irq_top #(
		.N_SRC (N_SRC)
	) u_irq_top (
		.clk         (clk),
		.reset       (reset),
		.bus         (bus),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.req         (req),
		.cmd         (cmd),
		.boundary    (boundary),
		.take        (take),
		.vector      (vector),
		.pending     (pending)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;           // 40 ns period
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[14:0], lfsr_bit()};
		end
		return val;
	endfunction

	// Random source number below N_SRC
	function automatic int rand_src();
		return int'(rand_bits(3)) % N_SRC;
	endfunction

	function automatic int lowest_index(input irq_mask_t mask);
		int idx;
		idx = -1;
		for (int i = 0; i < 8; i++) begin
			if (mask[i] && idx < 0) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("** Error at %0t: %s expected 8'h%02h, got 8'h%02h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			$display("** Error at %0t: %s expected 16'h%04h, got 16'h%04h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic bus_write(input addr_t addr, input data_t data);
		@(posedge clk);
		bus.addr  <= addr;
		bus.wdata <= data;
		bus.wr    <= 1'b1;
		@(posedge clk);
		bus.wr    <= 1'b0;
	endtask

	task automatic bus_read(input addr_t addr, output data_t data, output logic got);
		got  = 1'b0;
		data = '0;
		@(posedge clk);
		bus.addr <= addr;
		bus.rd   <= 1'b1;
		@(posedge clk);
		bus.rd   <= 1'b0;
		for (int i = 0; i < READ_TIMEOUT && !got; i++) begin
			@(negedge clk);
			if (rdata_valid) begin
				got  = 1'b1;
				data = rdata;
			end
		end
	endtask

	// Read a register and compare its value
	task automatic expect_reg(input string name, input addr_t addr, input data_t exp);
		data_t data;
		logic  got;
		bus_read(addr, data, got);
		if (!got) begin
			$display("Read of %s gave no rdata_valid within %0d cycles", name, READ_TIMEOUT);
			abort_run();
		end else begin
			check_data(name, exp, data);
		end
	endtask

	task automatic drive_req(input irq_mask_t levels);
		@(posedge clk);
		req <= levels;
	endtask

	task automatic pulse_req(input irq_mask_t mask);
		@(posedge clk);
		req <= req | mask;
		repeat (2) @(posedge clk);
		req <= req & ~mask;
	endtask

	task automatic send_cmd(input irq_cmd_t c);
		@(posedge clk);
		cmd <= c;
		@(posedge clk);
		cmd <= cmd_none;
	endtask

	task automatic pulse_boundary();
		@(posedge clk);
		boundary <= 1'b1;
		@(posedge clk);
		boundary <= 1'b0;
	endtask

	task automatic wait_take(output logic seen, output addr_t vec);
		seen = 1'b0;
		vec  = '0;
		for (int i = 0; i < TAKE_TIMEOUT && !seen; i++) begin
			@(negedge clk);
			if (take) begin
				seen = 1'b1;
				vec  = vector;
			end
		end
	endtask

	task automatic check_pending(input logic exp);
		@(negedge clk);
		check_bit("pending", exp, pending);
	endtask

	// Boundary followed by the expected take or by none
	task automatic boundary_expect(input logic exp_take, input int idx);
		logic  seen;
		addr_t vec;
		pulse_boundary();
		wait_take(seen, vec);
		check_bit("take", exp_take, seen);
		if (exp_take) begin
			check_addr("vector", VEC_BASE + addr_t'(8 * idx), vec);
		end
	endtask

	task automatic test_reset_state();
		expect_reg("ie", ADDR_IE, 8'h00);
		expect_reg("if", ADDR_IF, 8'hE0);  // Unimplemented bits read 1
		check_pending(1'b0);
		// Enabled flag while IME is still at its reset value
		bus_write(ADDR_IE, 8'h01);
		pulse_req(8'h01);
		wait_cycles(3);
		check_pending(1'b1);
		boundary_expect(1'b0, 0);
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_IE, 8'h00);
	endtask

	task automatic test_register_access();
		data_t val;
		repeat (4) begin
			val = data_t'(rand_bits(8));
			bus_write(ADDR_IE, val);
			expect_reg("ie", ADDR_IE, val);
		end
		val = data_t'(rand_bits(8));
		bus_write(ADDR_IF, val);
		expect_reg("if", ADDR_IF, val | 8'hE0);
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_IE, 8'h00);
		begin
			data_t data;
			logic  got;
			bus_read(16'hFF0E, data, got);
			check_bit("rdata_valid", 1'b0, got);
		end
	endtask

	task automatic test_edge_capture();
		irq_mask_t mask;
		mask = irq_mask_t'(1) << rand_src();
		drive_req(mask);                  // Held high from here
		wait_cycles(3);
		expect_reg("if", ADDR_IF, mask | 8'hE0);
		bus_write(ADDR_IF, 8'h00);
		wait_cycles(3);
		expect_reg("if", ADDR_IF, 8'hE0); // Level alone does not set again
		drive_req(8'h00);
		wait_cycles(3);
		drive_req(mask);
		wait_cycles(3);
		expect_reg("if", ADDR_IF, mask | 8'hE0);
		drive_req(8'h00);
		bus_write(ADDR_IF, 8'h00);
	endtask

	task automatic test_priority();
		irq_mask_t flags;
		int        idx;
		flags = irq_mask_t'(rand_bits(N_SRC));
		if (flags == 8'h00) begin
			flags = 8'h15;
		end
		bus_write(ADDR_IE, 8'hFF);
		send_cmd(cmd_ei);
		pulse_req(flags);
		wait_cycles(3);
		expect_reg("if", ADDR_IF, flags | 8'hE0);
		while (flags != 8'h00) begin
			idx = lowest_index(flags);
			boundary_expect(1'b1, idx);
			flags[idx] = 1'b0;
			expect_reg("if", ADDR_IF, flags | 8'hE0);
			send_cmd(cmd_reti);
		end
		check_pending(1'b0);
	endtask

	task automatic test_ime_gating();
		int        idx;
		irq_mask_t mask;
		idx  = rand_src();
		mask = irq_mask_t'(1) << idx;
		send_cmd(cmd_di);
		pulse_req(mask);
		wait_cycles(3);
		check_pending(1'b1);
		repeat (2) boundary_expect(1'b0, 0);
		send_cmd(cmd_ei);
		boundary_expect(1'b1, idx);
		pulse_req(mask);                  // New flag while IME is off
		wait_cycles(3);
		check_pending(1'b1);
		boundary_expect(1'b0, 0);
		bus_write(ADDR_IF, 8'h00);
	endtask

	task automatic test_ie_masking();
		int        idx;
		irq_mask_t mask;
		idx  = rand_src();
		mask = irq_mask_t'(1) << idx;
		bus_write(ADDR_IE, ~mask);
		send_cmd(cmd_ei);
		pulse_req(mask);
		wait_cycles(3);
		check_pending(1'b0);
		boundary_expect(1'b0, 0);
		bus_write(ADDR_IE, 8'hFF);
		check_pending(1'b1);
		boundary_expect(1'b1, idx);
		expect_reg("if", ADDR_IF, 8'hE0);
	endtask

	initial begin
		reset    = 1'b1;
		bus      = '0;
		req      = '0;
		cmd      = cmd_none;
		boundary = 1'b0;
		lfsr     = 32'h4260_c14f;
		apply_reset();
		test_reset_state();
		test_register_access();
		test_edge_capture();
		test_priority();
		test_ime_gating();
		test_ie_masking();
		// Load some state that the second reset must clear
		send_cmd(cmd_ei);
		pulse_req(8'h01);
		wait_cycles(3);
		apply_reset();
		test_reset_state();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
design/irq_pkg.sv
design/irq_sync.sv
design/irq_regs.sv
design/irq_dispatch.sv
design/irq_top.sv
test/irq_top_assert.sv
test/tb_irq_top.sv

/* Makefile */
# Verilator build and run of the interrupt controller testbench
TOP := tb_irq_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -Mdir obj_dir -f filelist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "Simulation ended without a result"; exit 1)

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
